//--- source/divsqrt_pkg.sv
// Widths here are only defaults and the top level parameters override them
package divsqrt_pkg;

  // ------------------------------
  // Widths
  // ------------------------------
  // Default operand and result width
  localparam int unsigned DATA_WIDTH = 16;
  // Default tag width
  localparam int unsigned TAG_WIDTH = 4;
  // Operation field width
  localparam int unsigned OP_WIDTH = 1;
  // Status flag width
  localparam int unsigned STATUS_WIDTH = 2;

  // ------------------------------
  // Encodings
  // ------------------------------
  // Operation codes
  localparam logic [OP_WIDTH-1:0] OP_DIV  = 1'b0;
  localparam logic [OP_WIDTH-1:0] OP_SQRT = 1'b1;

  // Status bit positions
  // Divide by zero
  localparam int unsigned STATUS_DZ = 0;
  // Inexact when the remainder is nonzero
  localparam int unsigned STATUS_NX = 1;

endpackage

//--- source/divsqrt_pipe.sv
// Zero stages make a pure wire path and flush clears the stage valids only, not the payload
module divsqrt_pipe #(
  parameter int unsigned NumRegs      = 0,
  parameter int unsigned PayloadWidth = 1
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  // Upstream handshake
  input  logic                    in_valid_i,
  input  logic [PayloadWidth-1:0] in_data_i,
  output logic                    in_ready_o,
  // Downstream handshake
  output logic                    out_valid_o,
  output logic [PayloadWidth-1:0] out_data_o,
  input  logic                    out_ready_i,
  // Some stage holds a valid item
  output logic                    busy_o
);

  // Index i is the signal after i register stages
  logic [NumRegs:0]        valid_q;
  logic [NumRegs:0]        ready;
  logic [PayloadWidth-1:0] data_q [NumRegs+1];

  // Stage zero is taken straight from the inputs
  assign valid_q[0] = in_valid_i;
  assign data_q[0]  = in_data_i;
  assign in_ready_o = ready[0];

  for (genvar i = 0; i < NumRegs; i++) begin : gen_stage
    logic reg_en;
    // Advance when the next stage takes data or only holds a bubble
    assign ready[i] = ready[i+1] | ~valid_q[i+1];
    // Payload moves only with a real item
    assign reg_en   = ready[i] & valid_q[i];

    // Stage valid with synchronous clear on flush
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (flush_i) begin
        valid_q[i+1] <= 1'b0;
      end else if (ready[i]) begin
        valid_q[i+1] <= valid_q[i];
      end
    end

    // Stage payload
    always_ff @(posedge clk_i) begin
      if (reg_en) begin
        data_q[i+1] <= data_q[i];
      end
    end
  end

  // Last stage faces downstream
  assign ready[NumRegs] = out_ready_i;
  assign out_valid_o    = valid_q[NumRegs];
  assign out_data_o     = data_q[NumRegs];

  // Only register stages count as work in flight
  if (NumRegs > 0) begin : gen_busy
    assign busy_o = |valid_q[NumRegs:1];
  end else begin : gen_no_busy
    assign busy_o = 1'b0;
  end

endmodule

//--- source/divsqrt_iter_unit.sv
// Unsigned operands only, DataWidth even and at least 4, result and status valid only with done_o
module divsqrt_iter_unit import divsqrt_pkg::*; #(
  parameter int unsigned DataWidth = DATA_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  // One cycle start pulses, taken only while ready_o is high
  input  logic                    div_start_i,
  input  logic                    sqrt_start_i,
  // Abort of the running operation
  input  logic                    kill_i,
  // Dividend or radicand in a, divisor in b
  input  logic [DataWidth-1:0]    op_a_i,
  input  logic [DataWidth-1:0]    op_b_i,
  output logic                    ready_o,
  output logic                    done_o,
  output logic [DataWidth-1:0]    result_o,
  output logic [STATUS_WIDTH-1:0] status_o
);

  // Two guard bits above the remainder for the root trial
  localparam int unsigned AccWidth = DataWidth + 2;
  localparam int unsigned CntWidth = $clog2(DataWidth);
  // Counter start values, one bit per cycle for divide and two for root
  localparam logic [CntWidth-1:0] DivLastCnt  = CntWidth'(DataWidth - 1);
  localparam logic [CntWidth-1:0] SqrtLastCnt = CntWidth'(DataWidth / 2 - 1);

  // Control state
  logic                 running_q;
  logic                 is_sqrt_q;
  logic                 dz_q;
  logic [CntWidth-1:0]  cnt_q;

  // Datapath registers
  logic [AccWidth-1:0]  acc_q;
  logic [AccWidth-1:0]  acc_d;
  logic [DataWidth-1:0] opnd_q;
  logic [DataWidth-1:0] opnd_d;
  logic [DataWidth-1:0] res_q;
  logic [DataWidth-1:0] res_d;
  logic [DataWidth-1:0] divisor_q;

  // Step signals
  logic                 start;
  logic                 last_iter;
  logic [AccWidth-1:0]  rem_shift;
  logic [AccWidth-1:0]  trial;

  // ------------------------------
  // Handshake
  // ------------------------------
  assign last_iter = running_q & (cnt_q == '0);
  // Done rides on the final iteration unless it gets killed
  assign done_o    = last_iter & ~kill_i;
  // Free again in the done cycle so a new start can follow at once
  assign ready_o   = ~running_q | done_o;
  assign start     = (div_start_i | sqrt_start_i) & ready_o & ~kill_i;

  // ------------------------------
  // Iteration step
  // ------------------------------
  always_comb begin
    if (is_sqrt_q) begin
      // Bring down two radicand bits and try 4r+1
      rem_shift = {acc_q[AccWidth-3:0], opnd_q[DataWidth-1 -: 2]};
      trial     = rem_shift - {res_q, 2'b01};
      opnd_d    = {opnd_q[DataWidth-3:0], 2'b00};
    end else begin
      // Bring down one dividend bit and try the divisor
      rem_shift = {acc_q[AccWidth-2:0], opnd_q[DataWidth-1]};
      trial     = rem_shift - {2'b00, divisor_q};
      opnd_d    = {opnd_q[DataWidth-2:0], 1'b0};
    end
    // Negative trial restores the shifted remainder
    if (trial[AccWidth-1]) begin
      acc_d = rem_shift;
      res_d = {res_q[DataWidth-2:0], 1'b0};
    end else begin
      acc_d = trial;
      res_d = {res_q[DataWidth-2:0], 1'b1};
    end
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      running_q <= 1'b0;
      is_sqrt_q <= 1'b0;
      dz_q      <= 1'b0;
      cnt_q     <= '0;
    end else if (kill_i) begin
      running_q <= 1'b0;
    end else if (start) begin
      running_q <= 1'b1;
      is_sqrt_q <= sqrt_start_i;
      // Zero divisor is noted at start
      dz_q      <= ~sqrt_start_i & (op_b_i == '0);
      cnt_q     <= sqrt_start_i ? SqrtLastCnt : DivLastCnt;
    end else if (running_q) begin
      if (last_iter) begin
        running_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end
  end

  // Operands enter at start, then shift once per cycle
  always_ff @(posedge clk_i) begin
    if (start) begin
      acc_q     <= '0;
      opnd_q    <= op_a_i;
      res_q     <= '0;
      divisor_q <= op_b_i;
    end else if (running_q) begin
      acc_q  <= acc_d;
      opnd_q <= opnd_d;
      res_q  <= res_d;
    end
  end

  // ------------------------------
  // Result
  // ------------------------------
  // Taken from the final step so it lines up with done
  // Zero divisor yields all ones since every trial succeeds
  assign result_o = res_d;

  always_comb begin
    status_o            = '0;
    status_o[STATUS_DZ] = dz_q;
    // Divide by zero reports no inexact
    status_o[STATUS_NX] = (acc_d != '0) & ~dz_q;
  end

endmodule

//--- source/divsqrt_ctrl.sv
// One operation at a time, and inputs offered in a flush cycle are refused
module divsqrt_ctrl import divsqrt_pkg::*; #(
  parameter int unsigned DataWidth = DATA_WIDTH,
  parameter int unsigned TagWidth  = TAG_WIDTH
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  // From the input pipe
  input  logic                    in_valid_i,
  input  logic [OP_WIDTH-1:0]     op_i,
  input  logic [TagWidth-1:0]     tag_i,
  output logic                    in_ready_o,
  // Unit side
  output logic                    div_start_o,
  output logic                    sqrt_start_o,
  input  logic                    unit_ready_i,
  input  logic                    unit_done_i,
  input  logic [DataWidth-1:0]    unit_result_i,
  input  logic [STATUS_WIDTH-1:0] unit_status_i,
  // To the output pipe
  output logic                    out_valid_o,
  output logic [DataWidth-1:0]    result_o,
  output logic [STATUS_WIDTH-1:0] status_o,
  output logic [TagWidth-1:0]     tag_o,
  input  logic                    out_ready_i,
  // Operation in the unit or held
  output logic                    busy_o
);

  // FSM encoding
  localparam logic [1:0] StateIdle = 2'd0;
  localparam logic [1:0] StateBusy = 2'd1;
  localparam logic [1:0] StateHold = 2'd2;

  logic [1:0]              state_q;
  logic [1:0]              state_d;
  logic                    op_start;
  logic                    hold_en;
  logic [TagWidth-1:0]     tag_q;
  logic [DataWidth-1:0]    held_result_q;
  logic [STATUS_WIDTH-1:0] held_status_q;

  // ------------------------------
  // Start generation
  // ------------------------------
  // in_ready_o already drops on flush and without unit ready
  assign op_start     = in_valid_i & in_ready_o;
  assign div_start_o  = op_start & (op_i == OP_DIV);
  assign sqrt_start_o = op_start & (op_i == OP_SQRT);

  // ------------------------------
  // Control FSM
  // ------------------------------
  always_comb begin
    in_ready_o  = 1'b0;
    out_valid_o = 1'b0;
    busy_o      = 1'b0;
    state_d     = state_q;

    case (state_q)
      // Waiting for work
      StateIdle: begin
        in_ready_o = unit_ready_i;
        if (in_valid_i && unit_ready_i) begin
          state_d = StateBusy;
        end
      end
      // Unit running
      StateBusy: begin
        busy_o = 1'b1;
        if (unit_done_i) begin
          out_valid_o = 1'b1;
          if (out_ready_i) begin
            // Result gone, back to back start possible
            in_ready_o = unit_ready_i;
            state_d    = (in_valid_i && unit_ready_i) ? StateBusy : StateIdle;
          end else begin
            state_d = StateHold;
          end
        end
      end
      // Result parked until downstream takes it
      StateHold: begin
        busy_o      = 1'b1;
        out_valid_o = 1'b1;
        if (out_ready_i) begin
          in_ready_o = unit_ready_i;
          state_d    = (in_valid_i && unit_ready_i) ? StateBusy : StateIdle;
        end
      end
      default: state_d = StateIdle;
    endcase

    // Flush wins over everything
    if (flush_i) begin
      in_ready_o  = 1'b0;
      out_valid_o = 1'b0;
      busy_o      = 1'b0;
      state_d     = StateIdle;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= StateIdle;
    end else begin
      state_q <= state_d;
    end
  end

  // ------------------------------
  // Tag and hold register
  // ------------------------------
  // Done cycle without acceptance parks the result
  assign hold_en = unit_done_i & (state_q == StateBusy) & ~out_ready_i & ~flush_i;

  always_ff @(posedge clk_i) begin
    if (op_start) begin
      tag_q <= tag_i;
    end
    if (hold_en) begin
      held_result_q <= unit_result_i;
      held_status_q <= unit_status_i;
    end
  end

  // Held value has priority while in hold
  assign result_o = (state_q == StateHold) ? held_result_q : unit_result_i;
  assign status_o = (state_q == StateHold) ? held_status_q : unit_status_i;
  assign tag_o    = tag_q;

endmodule

//--- source/divsqrt_multi.sv
// Inputs offered in a flush cycle are dropped and results leave strictly in input order
module divsqrt_multi import divsqrt_pkg::*; #(
  parameter int unsigned DataWidth  = DATA_WIDTH,
  parameter int unsigned TagWidth   = TAG_WIDTH,
  parameter int unsigned NumInpRegs = 0,
  parameter int unsigned NumOutRegs = 0
) (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  logic                    flush_i,
  // Input side
  input  logic                    in_valid_i,
  input  logic [DataWidth-1:0]    op_a_i,
  input  logic [DataWidth-1:0]    op_b_i,
  input  logic [OP_WIDTH-1:0]     op_i,
  input  logic [TagWidth-1:0]     tag_i,
  output logic                    in_ready_o,
  // Output side
  output logic                    out_valid_o,
  output logic [DataWidth-1:0]    result_o,
  output logic [STATUS_WIDTH-1:0] status_o,
  output logic [TagWidth-1:0]     tag_o,
  input  logic                    out_ready_i,
  // Work somewhere in flight
  output logic                    busy_o
);

  // Payload is op, tag and both operands on the way in
  localparam int unsigned InpPayloadWidth = OP_WIDTH + TagWidth + 2 * DataWidth;
  // Payload is tag, status and result on the way out
  localparam int unsigned OutPayloadWidth = TagWidth + STATUS_WIDTH + DataWidth;

  // Input pipe outputs
  logic                       inp_valid;
  logic                       inp_ready;
  logic                       inp_busy;
  logic [InpPayloadWidth-1:0] inp_data;
  logic [DataWidth-1:0]       inp_a;
  logic [DataWidth-1:0]       inp_b;
  logic [OP_WIDTH-1:0]        inp_op;
  logic [TagWidth-1:0]        inp_tag;

  // Unit handshake
  logic                       div_start;
  logic                       sqrt_start;
  logic                       unit_ready;
  logic                       unit_done;
  logic [DataWidth-1:0]       unit_result;
  logic [STATUS_WIDTH-1:0]    unit_status;

  // Control to output pipe
  logic                       ctrl_valid;
  logic                       ctrl_busy;
  logic [DataWidth-1:0]       ctrl_result;
  logic [STATUS_WIDTH-1:0]    ctrl_status;
  logic [TagWidth-1:0]        ctrl_tag;
  logic                       out_pipe_ready;
  logic                       out_busy;
  logic [OutPayloadWidth-1:0] out_data;

  // ------------------------------
  // Input side
  // ------------------------------
  divsqrt_pipe #(
    .NumRegs      ( NumInpRegs      ),
    .PayloadWidth ( InpPayloadWidth )
  ) i_inp_pipe (
    .clk_i       ( clk_i                          ),
    .rst_n_i     ( rst_n_i                        ),
    .flush_i     ( flush_i                        ),
    .in_valid_i  ( in_valid_i                     ),
    .in_data_i   ( {op_i, tag_i, op_b_i, op_a_i}  ),
    .in_ready_o  ( in_ready_o                     ),
    .out_valid_o ( inp_valid                      ),
    .out_data_o  ( inp_data                       ),
    .out_ready_i ( inp_ready                      ),
    .busy_o      ( inp_busy                       )
  );

  assign {inp_op, inp_tag, inp_b, inp_a} = inp_data;

  // ------------------------------
  // Control and unit
  // ------------------------------
  divsqrt_ctrl #(
    .DataWidth ( DataWidth ),
    .TagWidth  ( TagWidth  )
  ) i_ctrl (
    .clk_i         ( clk_i          ),
    .rst_n_i       ( rst_n_i        ),
    .flush_i       ( flush_i        ),
    .in_valid_i    ( inp_valid      ),
    .op_i          ( inp_op         ),
    .tag_i         ( inp_tag        ),
    .in_ready_o    ( inp_ready      ),
    .div_start_o   ( div_start      ),
    .sqrt_start_o  ( sqrt_start     ),
    .unit_ready_i  ( unit_ready     ),
    .unit_done_i   ( unit_done      ),
    .unit_result_i ( unit_result    ),
    .unit_status_i ( unit_status    ),
    .out_valid_o   ( ctrl_valid     ),
    .result_o      ( ctrl_result    ),
    .status_o      ( ctrl_status    ),
    .tag_o         ( ctrl_tag       ),
    .out_ready_i   ( out_pipe_ready ),
    .busy_o        ( ctrl_busy      )
  );

  // Operands bypass control and go straight to the unit
  divsqrt_iter_unit #(
    .DataWidth ( DataWidth )
  ) i_unit (
    .clk_i        ( clk_i       ),
    .rst_n_i      ( rst_n_i     ),
    .div_start_i  ( div_start   ),
    .sqrt_start_i ( sqrt_start  ),
    .kill_i       ( flush_i     ),
    .op_a_i       ( inp_a       ),
    .op_b_i       ( inp_b       ),
    .ready_o      ( unit_ready  ),
    .done_o       ( unit_done   ),
    .result_o     ( unit_result ),
    .status_o     ( unit_status )
  );

  // ------------------------------
  // Output side
  // ------------------------------
  divsqrt_pipe #(
    .NumRegs      ( NumOutRegs      ),
    .PayloadWidth ( OutPayloadWidth )
  ) i_out_pipe (
    .clk_i       ( clk_i                                 ),
    .rst_n_i     ( rst_n_i                               ),
    .flush_i     ( flush_i                               ),
    .in_valid_i  ( ctrl_valid                            ),
    .in_data_i   ( {ctrl_tag, ctrl_status, ctrl_result}  ),
    .in_ready_o  ( out_pipe_ready                        ),
    .out_valid_o ( out_valid_o                           ),
    .out_data_o  ( out_data                              ),
    .out_ready_i ( out_ready_i                           ),
    .busy_o      ( out_busy                              )
  );

  assign {tag_o, status_o, result_o} = out_data;

  // Any stage, the unit or the hold register counts
  assign busy_o = inp_busy | ctrl_busy | out_busy;

endmodule

//--- sim/tb_divsqrt_checks.svh
// Included inside the testbench module and relies on its stop_on_error task and package import
`ifndef TB_DIVSQRT_CHECKS_SVH
`define TB_DIVSQRT_CHECKS_SVH

// ------------------------------
// Reference model
// ------------------------------
// Quotient, all ones for a zero divisor, or the floor of the root of a
function automatic logic [DATA_WIDTH-1:0] model_result(input logic [OP_WIDTH-1:0] op_v,
                                                       input logic [DATA_WIDTH-1:0] a_v,
                                                       input logic [DATA_WIDTH-1:0] b_v);
  logic [63:0] root;
  if (op_v == OP_SQRT) begin
    root = '0;
    // Grow the root while the next square still fits under a
    while ((root + 64'd1) * (root + 64'd1) <= 64'(a_v)) begin
      root = root + 64'd1;
    end
    return DATA_WIDTH'(root);
  end
  if (b_v == '0) begin
    return '1;
  end
  return a_v / b_v;
endfunction

// Divide by zero alone for a zero divisor, else inexact on a leftover
function automatic logic [STATUS_WIDTH-1:0] model_status(input logic [OP_WIDTH-1:0] op_v,
                                                         input logic [DATA_WIDTH-1:0] a_v,
                                                         input logic [DATA_WIDTH-1:0] b_v);
  logic [STATUS_WIDTH-1:0] flags;
  logic [63:0]             root;
  flags = '0;
  if (op_v == OP_SQRT) begin
    root = 64'(model_result(op_v, a_v, b_v));
    flags[STATUS_NX] = (root * root) != 64'(a_v);
  end else if (b_v == '0) begin
    flags[STATUS_DZ] = 1'b1;
  end else begin
    flags[STATUS_NX] = (a_v % b_v) != '0;
  end
  return flags;
endfunction

// ------------------------------
// Compare tasks
// ------------------------------
task automatic check_result(input string name, input logic [DATA_WIDTH-1:0] got,
                            input logic [DATA_WIDTH-1:0] exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_status(input string name, input logic [STATUS_WIDTH-1:0] got,
                            input logic [STATUS_WIDTH-1:0] exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
    stop_on_error();
  end
endtask

task automatic check_tag(input string name, input logic [TAG_WIDTH-1:0] got,
                         input logic [TAG_WIDTH-1:0] exp);
  if (got !== exp) begin
    $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
    stop_on_error();
  end
endtask

`endif

//--- sim/tb_divsqrt_multi.sv
// One input and one output register stage, fixed seed, every output checked in input order
module tb_divsqrt_multi import divsqrt_pkg::*; ();

  localparam int unsigned NumInpRegs   = 1;
  localparam int unsigned NumOutRegs   = 1;
  localparam int unsigned SendTimeout  = 200;
  localparam int unsigned DrainTimeout = 4000;

  logic                    clk;
  logic                    rst_n;
  logic                    flush;
  logic                    in_valid;
  logic [DATA_WIDTH-1:0]   op_a;
  logic [DATA_WIDTH-1:0]   op_b;
  logic [OP_WIDTH-1:0]     op;
  logic [TAG_WIDTH-1:0]    tag;
  logic                    in_ready;
  logic                    out_valid;
  logic [DATA_WIDTH-1:0]   result;
  logic [STATUS_WIDTH-1:0] status;
  logic [TAG_WIDTH-1:0]    out_tag;
  logic                    out_ready;
  logic                    busy;

  integer seed = 60621;
  // Output ready policy, 0 always, 1 random, 2 stalled
  int     ready_mode;

  // Scoreboard in acceptance order
  logic [DATA_WIDTH-1:0]   exp_result_q [$];
  logic [STATUS_WIDTH-1:0] exp_status_q [$];
  logic [TAG_WIDTH-1:0]    exp_tag_q [$];

  // Output seen stalled in the previous cycle
  logic                    prev_hold;
  logic [DATA_WIDTH-1:0]   prev_result;
  logic [STATUS_WIDTH-1:0] prev_status;
  logic [TAG_WIDTH-1:0]    prev_tag;

  divsqrt_multi #(
    .DataWidth  ( DATA_WIDTH ),
    .TagWidth   ( TAG_WIDTH  ),
    .NumInpRegs ( NumInpRegs ),
    .NumOutRegs ( NumOutRegs )
  ) i_divsqrt_multi (
    .clk_i       ( clk       ),
    .rst_n_i     ( rst_n     ),
    .flush_i     ( flush     ),
    .in_valid_i  ( in_valid  ),
    .op_a_i      ( op_a      ),
    .op_b_i      ( op_b      ),
    .op_i        ( op        ),
    .tag_i       ( tag       ),
    .in_ready_o  ( in_ready  ),
    .out_valid_o ( out_valid ),
    .result_o    ( result    ),
    .status_o    ( status    ),
    .tag_o       ( out_tag   ),
    .out_ready_i ( out_ready ),
    .busy_o      ( busy      )
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  `include "tb_divsqrt_checks.svh"

  // ------------------------------
  // Driving
  // ------------------------------
  // Step to just after the next rising edge and set the output ready
  task automatic next_cycle();
    @(posedge clk);
    #1;
    case (ready_mode)
      0:       out_ready = 1'b1;
      1:       out_ready = 1'($random(seed));
      default: out_ready = 1'b0;
    endcase
  endtask

  // Hold one operation on the input until it is taken
  task automatic send_op(input logic [OP_WIDTH-1:0] op_v, input logic [DATA_WIDTH-1:0] a_v,
                         input logic [DATA_WIDTH-1:0] b_v, input logic [TAG_WIDTH-1:0] tag_v);
    int unsigned waited;
    logic        taken;
    waited   = 0;
    taken    = 1'b0;
    in_valid = 1'b1;
    op       = op_v;
    op_a     = a_v;
    op_b     = b_v;
    tag      = tag_v;
    while (!taken) begin
      @(negedge clk);
      taken = in_ready;
      next_cycle();
      waited++;
      if (!taken && waited >= SendTimeout) begin
        $display("timeout: input not accepted within %0d cycles", SendTimeout);
        stop_on_error();
      end
    end
    in_valid = 1'b0;
  endtask

  // Kind 0 divides, 1 takes roots, 2 mixes both
  task automatic send_random(input int unsigned kind);
    logic [OP_WIDTH-1:0]   op_v;
    logic [DATA_WIDTH-1:0] a_v;
    logic [DATA_WIDTH-1:0] b_v;
    logic [TAG_WIDTH-1:0]  tag_v;
    int unsigned           gap;
    a_v   = DATA_WIDTH'($random(seed));
    b_v   = DATA_WIDTH'($random(seed));
    tag_v = TAG_WIDTH'($random(seed));
    // Roughly one divisor in ten is zero
    if (($unsigned($random(seed)) % 10) == 0) begin
      b_v = '0;
    end
    case (kind)
      0:       op_v = OP_DIV;
      1:       op_v = OP_SQRT;
      default: op_v = OP_WIDTH'($random(seed));
    endcase
    gap = $unsigned($random(seed)) % 3;
    send_op(op_v, a_v, b_v, tag_v);
    repeat (gap) next_cycle();
  endtask

  task automatic wait_drain();
    int unsigned waited;
    waited = 0;
    while (exp_result_q.size() != 0) begin
      next_cycle();
      waited++;
      if (waited >= DrainTimeout) begin
        $display("timeout: %0d results still missing", exp_result_q.size());
        stop_on_error();
      end
    end
  endtask

  // No output may appear for a number of cycles
  task automatic check_quiet(input int unsigned cycles);
    repeat (cycles) begin
      @(negedge clk);
      if (out_valid !== 1'b0) begin
        $display("a result appeared at %0t although nothing is pending", $time);
        stop_on_error();
      end
      next_cycle();
    end
  endtask

  // ------------------------------
  // Monitor and scoreboard
  // ------------------------------
  // Sampled mid cycle where inputs and outputs are settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (prev_hold && !flush) begin
        if (out_valid !== 1'b1) begin
          $display("out_valid_o dropped at %0t before the result was taken", $time);
          stop_on_error();
        end
        check_result("result_o held", result, prev_result);
        check_status("status_o held", status, prev_status);
        check_tag("tag_o held", out_tag, prev_tag);
      end
      if (out_valid && out_ready && !flush) begin
        if (exp_result_q.size() == 0) begin
          $display("result taken at %0t with no operation pending", $time);
          stop_on_error();
        end else begin
          check_result("result_o", result, exp_result_q.pop_front());
          check_status("status_o", status, exp_status_q.pop_front());
          check_tag("tag_o", out_tag, exp_tag_q.pop_front());
        end
      end
      if (in_valid && in_ready && !flush) begin
        exp_result_q.push_back(model_result(op, op_a, op_b));
        exp_status_q.push_back(model_status(op, op_a, op_b));
        exp_tag_q.push_back(tag);
      end
      // Flush discards everything in flight
      if (flush) begin
        exp_result_q.delete();
        exp_status_q.delete();
        exp_tag_q.delete();
      end
      prev_hold   = out_valid && !out_ready && !flush;
      prev_result = result;
      prev_status = status;
      prev_tag    = out_tag;
    end else begin
      prev_hold = 1'b0;
    end
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    ready_mode  = 0;
    prev_hold   = 1'b0;
    rst_n       = 1'b0;
    flush       = 1'b0;
    in_valid    = 1'b0;
    op_a        = '0;
    op_b        = '0;
    op          = OP_DIV;
    tag         = '0;
    out_ready   = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // Idle outputs before any input
    @(negedge clk);
    if (out_valid !== 1'b0 || busy !== 1'b0 || in_ready !== 1'b1) begin
      $display("wrong idle outputs after reset: valid %b busy %b ready %b",
               out_valid, busy, in_ready);
      stop_on_error();
    end
    next_cycle();

    repeat (40) send_random(0);
    wait_drain();
    repeat (40) send_random(1);
    wait_drain();

    // Random back-pressure and input gaps
    ready_mode = 1;
    repeat (80) send_random(2);
    wait_drain();

    // Long stall so a finished result waits in the hold register
    ready_mode = 2;
    repeat (3) send_random(2);
    repeat (20) next_cycle();
    ready_mode = 0;
    wait_drain();

    // Stall the output, then flush with work in flight
    ready_mode = 2;
    repeat (3) send_random(2);
    repeat (4) next_cycle();
    flush = 1'b1;
    next_cycle();
    flush = 1'b0;
    @(negedge clk);
    if (busy !== 1'b0) begin
      $display("busy_o still high at %0t in the cycle after the flush", $time);
      stop_on_error();
    end
    ready_mode = 0;
    next_cycle();
    check_quiet(20);

    // Fresh work after the flush
    ready_mode = 1;
    repeat (20) send_random(2);
    wait_drain();

    $display("Simulation PASSED");
    $finish;
  end

endmodule

//--- verilog.f
+incdir+sim
source/divsqrt_pkg.sv
source/divsqrt_pipe.sv
source/divsqrt_iter_unit.sv
source/divsqrt_ctrl.sv
source/divsqrt_multi.sv
sim/tb_divsqrt_multi.sv

//--- Makefile
# Verilator flow for the divide and square root unit
# Any variable below can be overridden on the command line

VERILATOR  ?= verilator
FILELIST   ?= verilog.f
TB_TOP     ?= tb_divsqrt_multi
RTL_TOP    ?= divsqrt_multi
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_TEXT  ?= Simulation PASSED
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -Wno-fatal -j 0

.PHONY: all lint build sim clean

all: sim

# Lint the design from the RTL top level
lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

# Build the testbench executable
build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Run and judge the run by the log
sim: build
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "pass text not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
